// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
TOP       ?= lsq_tb
FILELIST  ?= build.f

BIN  := obj_dir/V$(TOP)
LOG  := sim.log
SRCS := $(wildcard include/*.svh source/*.sv sim/*.sv)

.PHONY: all run check clean

all: check

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)

check: run
	@! grep -q "TESTS FAILED" $(LOG)
	@grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: build.f
+incdir+include
source/lsq_pkg.sv
source/load_store_buffer.sv
source/alu_unit.sv
source/cdb_arbiter.sv
source/data_memory.sv
source/lsq_top.sv
sim/lsq_tb.sv

// File: include/lsq_defs.svh
`ifndef LSQ_DEFS_SVH
`define LSQ_DEFS_SVH

// tag width, tag 0 marks an operand that is already valid
`define LSQ_TAG_W 4

// one buffer entry per tag value
`define LSQ_ENTRIES (1 << `LSQ_TAG_W)

// data and address width
`define LSQ_DATA_W 32

// data memory depth in 32-bit words
`define LSQ_MEM_WORDS 256

// cycles from request to response
`define LSQ_MEM_LAT 2

`endif

// File: sim/lsq_tb.sv
`timescale 1ns/1ns
`include "lsq_defs.svh"

module lsq_tb;
    import lsq_pkg::*;

    logic                  clk;
    logic                  arst_n;
    logic                  clr;
    dispatch_t             disp;
    logic                  commit_valid;
    logic [`LSQ_TAG_W-1:0] commit_tag;
    cdb_t                  cdb;
    logic                  full;
    logic                  alu_full;

    // byte-wide shadow of the data memory
    logic [7:0]             shadow [4*`LSQ_MEM_WORDS];
    logic [`LSQ_DATA_W-1:0] exp_val [`LSQ_ENTRIES];
    logic [`LSQ_ENTRIES-1:0] exp_live;
    // every broadcast per tag, duplicates included
    int                     bcast_cnt [`LSQ_ENTRIES];

    string cur_test;
    int    err_cnt;
    int    err_at_start;
    int    n_checks;
    int    n_seen;
    int    n_disp;
    int    cycles;

    lsq_top i_dut (
        .clk          (clk),
        .arst_n       (arst_n),
        .clr          (clr),
        .disp         (disp),
        .commit_valid (commit_valid),
        .commit_tag   (commit_tag),
        .cdb          (cdb),
        .full         (full),
        .alu_full     (alu_full)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // expected result of an alu op or a little-endian load
    function automatic logic [31:0] ref_value(input op_e op, input logic [31:0] base,
                                              input logic [31:0] imm, input logic [31:0] a,
                                              input logic [31:0] b);
        logic [31:0] addr;
        logic [7:0]  b0;
        logic [7:0]  b1;
        logic [7:0]  b2;
        logic [7:0]  b3;
        addr = base + imm;
        b0 = shadow[addr[9:0]];
        b1 = shadow[addr[9:0] + 10'd1];
        b2 = shadow[addr[9:0] + 10'd2];
        b3 = shadow[addr[9:0] + 10'd3];
        case (op)
            ADD:     return a + b;
            SUB:     return a - b;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            LB:      return {{24{b0[7]}}, b0};
            LBU:     return {24'h0, b0};
            LH:      return {{16{b1[7]}}, b1, b0};
            LHU:     return {16'h0, b1, b0};
            LW:      return {b3, b2, b1, b0};
            default: return '0;
        endcase
    endfunction

    task automatic store_shadow(input op_e op, input logic [31:0] addr, input logic [31:0] d);
        shadow[addr[9:0]] = d[7:0];
        if (op != SB) begin
            shadow[addr[9:0] + 10'd1] = d[15:8];
        end
        if (op == SW) begin
            shadow[addr[9:0] + 10'd2] = d[23:16];
            shadow[addr[9:0] + 10'd3] = d[31:24];
        end
    endtask

    function automatic logic [31:0] align_addr(input op_e op, input logic [31:0] a);
        if (op inside {LW, SW}) begin
            return a & 32'h3fc;
        end else if (op inside {LH, LHU, SH}) begin
            return a & 32'h3fe;
        end
        return a & 32'h3ff;
    endfunction

    function automatic op_e pick_alu_op(input int r);
        case (r % 5)
            0:       return ADD;
            1:       return SUB;
            2:       return AND;
            3:       return OR;
            default: return XOR;
        endcase
    endfunction

    function automatic op_e pick_load_op(input int r);
        case (r % 5)
            0:       return LB;
            1:       return LBU;
            2:       return LH;
            3:       return LHU;
            default: return LW;
        endcase
    endfunction

    task automatic check_val(input string name, input logic [31:0] expv,
                             input logic [31:0] act);
        n_checks++;
        if (act !== expv) begin
            $display("ERR %s expected %h actual %h", name, expv, act);
            err_cnt++;
        end
    endtask

    // one dispatch held for a single cycle once the target block has room
    task automatic send(input op_e op, input logic [`LSQ_TAG_W-1:0] dest,
                        input logic [31:0] imm, input logic [`LSQ_TAG_W-1:0] t1,
                        input logic [31:0] d1, input logic [`LSQ_TAG_W-1:0] t2,
                        input logic [31:0] d2, input logic expect_res,
                        input logic [31:0] value);
        logic is_alu;
        is_alu = op inside {ADD, SUB, AND, OR, XOR};
        do begin
            @(negedge clk);
        end while (is_alu ? alu_full : full);
        @(posedge clk);
        if (expect_res) begin
            exp_val[dest]  = value;
            exp_live[dest] = 1'b1;
        end
        disp <= '{valid: 1'b1, op: op, dest: dest, imm: imm, src1_tag: t1,
                  src1_data: d1, src2_tag: t2, src2_data: d2};
        n_disp++;
        @(posedge clk);
        disp <= '0;
    endtask

    task automatic commit_store(input logic [`LSQ_TAG_W-1:0] t);
        @(posedge clk);
        commit_valid <= 1'b1;
        commit_tag   <= t;
        @(posedge clk);
        commit_valid <= 1'b0;
    endtask

    task automatic drain();
        while (exp_live != '0) begin
            @(posedge clk);
        end
    endtask

    task automatic flush();
        @(posedge clk);
        clr <= 1'b1;
        @(posedge clk);
        clr <= 1'b0;
        exp_live = '0;
    endtask

    task automatic begin_test(input string name);
        cur_test     = name;
        err_at_start = err_cnt;
    endtask

    task automatic end_test();
        $display("test %s: %s", cur_test, (err_cnt == err_at_start) ? "ok" : "failed");
    endtask

    // every broadcast must match a live expected tag
    always @(negedge clk) begin
        if (arst_n && cdb.valid) begin
            bcast_cnt[cdb.tag]++;
            if (!exp_live[cdb.tag]) begin
                $display("unexpected broadcast of tag %0d in test %s", cdb.tag, cur_test);
                err_cnt++;
            end else begin
                check_val(cur_test, exp_val[cdb.tag], cdb.data);
                exp_live[cdb.tag] = 1'b0;
                n_seen++;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > 40 * n_disp + 200) begin
            $display("run stopped after %0d cycles, a result never arrived", cycles);
            $display("TESTS FAILED");
            $finish;
        end
    end

    initial begin
        logic [31:0] addr;
        logic [31:0] imm;
        logic [31:0] data;
        logic [31:0] v;
        logic [31:0] ld;
        op_e         op;

        void'($urandom(89));
        err_cnt  = 0;
        n_checks = 0;
        n_seen   = 0;
        n_disp   = 0;
        cycles   = 0;
        exp_live = '0;
        for (int i = 0; i < 4 * `LSQ_MEM_WORDS; i++) begin
            shadow[i] = 8'h00;
        end
        arst_n       <= 1'b0;
        clr          <= 1'b0;
        disp         <= '0;
        commit_valid <= 1'b0;
        commit_tag   <= '0;
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;

        begin_test("sized_access");
        for (int n = 0; n < 6; n++) begin
            op   = (n % 3 == 0) ? SB : (n % 3 == 1) ? SH : SW;
            addr = align_addr(op, $urandom);
            imm  = $urandom % 16;
            if (imm > addr) begin
                imm = 0;
            end
            data = $urandom;
            send(op, 1, imm, 0, addr - imm, 0, data, 1'b0, 0);
            commit_store(1);
            store_shadow(op, addr, data);
            for (int k = 0; k < 5; k++) begin
                op = pick_load_op(k);
                v  = align_addr(op, addr);
                send(op, `LSQ_TAG_W'(2 + k), 0, 0, v, 0, 0, 1'b1,
                     ref_value(op, v, 0, 0, 0));
            end
            drain();
        end
        end_test();

        begin_test("wakeup");
        data = $urandom;
        send(SW, 5, 0, 0, 32'h104, 0, data, 1'b0, 0);
        commit_store(5);
        store_shadow(SW, 32'h104, data);
        // load base comes from the alu result on tag 1
        send(ADD, 1, 0, 0, 32'h0f0, 0, 32'h010, 1'b1, 32'h100);
        send(LW, 2, 4, 1, 0, 0, 0, 1'b1, ref_value(LW, 32'h100, 4, 0, 0));
        ld = ref_value(LW, 32'h104, 0, 0, 0);
        send(LW, 3, 0, 0, 32'h104, 0, 0, 1'b1, ld);
        send(ADD, 4, 0, 3, 0, 0, 5, 1'b1, ref_value(ADD, 0, 0, ld, 5));
        drain();
        end_test();

        begin_test("commit_order");
        data = $urandom;
        send(SW, 1, 0, 0, 32'h200, 0, data, 1'b0, 0);
        send(LW, 2, 0, 0, 32'h200, 0, 0, 1'b1, ref_value(LW, 32'h200, 0, 0, 0));
        drain();
        commit_store(1);
        store_shadow(SW, 32'h200, data);
        send(LW, 3, 0, 0, 32'h200, 0, 0, 1'b1, ref_value(LW, 32'h200, 0, 0, 0));
        drain();
        end_test();

        begin_test("cdb_sharing");
        for (int t = 0; t < `LSQ_ENTRIES; t++) begin
            bcast_cnt[t] = 0;
        end
        for (int t = 1; t <= 14; t++) begin
            if (t % 2 == 1) begin
                op   = pick_alu_op($urandom);
                addr = $urandom;
                data = $urandom;
                send(op, `LSQ_TAG_W'(t), 0, 0, addr, 0, data, 1'b1,
                     ref_value(op, 0, 0, addr, data));
            end else begin
                op   = pick_load_op($urandom);
                addr = align_addr(op, $urandom);
                send(op, `LSQ_TAG_W'(t), 0, 0, addr, 0, 0, 1'b1,
                     ref_value(op, addr, 0, 0, 0));
            end
        end
        drain();
        // each dispatched tag exactly once, no other tag at all
        for (int t = 0; t < `LSQ_ENTRIES; t++) begin
            check_val($sformatf("cdb_sharing/tag%0d_count", t),
                      (t >= 1 && t <= 14) ? 1 : 0, bcast_cnt[t]);
        end
        end_test();

        begin_test("full_flush");
        // circular base dependencies keep all of these loads waiting
        for (int t = 1; t <= 15; t++) begin
            send(LW, `LSQ_TAG_W'(t), 0, `LSQ_TAG_W'((t % 15) + 1), 0, 0, 0, 1'b0, 0);
        end
        @(negedge clk);
        check_val("full_flush/full_high", 1, 32'(full));
        flush();
        @(negedge clk);
        check_val("full_flush/full_low", 0, 32'(full));
        send(ADD, 1, 0, 3, 0, 0, 1, 1'b0, 0);
        send(ADD, 2, 0, 3, 0, 0, 2, 1'b0, 0);
        @(negedge clk);
        check_val("full_flush/alu_full_high", 1, 32'(alu_full));
        flush();
        @(negedge clk);
        check_val("full_flush/alu_full_low", 0, 32'(alu_full));
        check_val("full_flush/full_low_again", 0, 32'(full));
        // alu result still heading for the hold register when clr arrives
        send(ADD, 6, 0, 0, 32'h1, 0, 32'h2, 1'b0, 0);
        flush();
        // load access still inside the memory pipe when clr arrives
        send(LW, 5, 0, 0, 32'h104, 0, 0, 1'b0, 0);
        flush();
        // any broadcast here is a stale tag
        repeat (20) @(negedge clk);
        send(LW, 4, 0, 0, 32'h104, 0, 0, 1'b1, ref_value(LW, 32'h104, 0, 0, 0));
        drain();
        end_test();

        $display("checks %0d, results %0d, errors %0d", n_checks, n_seen, err_cnt);
        if (err_cnt == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: source/alu_unit.sv
`timescale 1ns/1ns
`include "lsq_defs.svh"

module alu_unit (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               clr,
    input  lsq_pkg::dispatch_t disp,
    input  lsq_pkg::cdb_t      cdb,
    input  logic               alu_busy,
    output lsq_pkg::cdb_t      alu_res,
    output logic               alu_full
);
    import lsq_pkg::*;

    logic [1:0] ent_valid;
    logic [1:0] s1_rdy;
    logic [1:0] s2_rdy;
    // slot holding the older entry
    logic       older;

    op_e                    ent_op   [2];
    logic [`LSQ_TAG_W-1:0]  ent_dest [2];
    logic [`LSQ_TAG_W-1:0]  s1_tag   [2];
    logic [`LSQ_TAG_W-1:0]  s2_tag   [2];
    logic [`LSQ_DATA_W-1:0] s1_data  [2];
    logic [`LSQ_DATA_W-1:0] s2_data  [2];

    logic                   disp_hit;
    logic                   disp_slot;
    logic [1:0]             ready;
    logic                   issue_go;
    logic                   issue_slot;
    logic [`LSQ_DATA_W-1:0] result;

    assign disp_hit  = disp.valid && (disp.op inside {ADD, SUB, AND, OR, XOR});
    // first free slot
    assign disp_slot = ent_valid[0];
    assign alu_full  = &ent_valid;

    assign ready = ent_valid & s1_rdy & s2_rdy;
    // the hold register must capture the last result before a new one appears
    assign issue_go   = (|ready) && !alu_busy && !alu_res.valid;
    assign issue_slot = (&ready) ? older : ready[1];

    always_comb begin
        case (ent_op[issue_slot])
            ADD:     result = s1_data[issue_slot] + s2_data[issue_slot];
            SUB:     result = s1_data[issue_slot] - s2_data[issue_slot];
            AND:     result = s1_data[issue_slot] & s2_data[issue_slot];
            OR:      result = s1_data[issue_slot] | s2_data[issue_slot];
            XOR:     result = s1_data[issue_slot] ^ s2_data[issue_slot];
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ent_valid <= '0;
            s1_rdy    <= '0;
            s2_rdy    <= '0;
            older     <= 1'b0;
            alu_res   <= '0;
        end else if (clr) begin
            ent_valid     <= '0;
            alu_res.valid <= 1'b0;
        end else begin
            for (int k = 0; k < 2; k++) begin
                if (cdb.valid && cdb.tag == s1_tag[k]) begin
                    s1_rdy[k] <= 1'b1;
                end
                if (cdb.valid && cdb.tag == s2_tag[k]) begin
                    s2_rdy[k] <= 1'b1;
                end
            end
            if (issue_go) begin
                ent_valid[issue_slot] <= 1'b0;
            end
            if (disp_hit) begin
                ent_valid[disp_slot] <= 1'b1;
                s1_rdy[disp_slot]    <= (disp.src1_tag == '0)
                                        || (cdb.valid && cdb.tag == disp.src1_tag);
                s2_rdy[disp_slot]    <= (disp.src2_tag == '0)
                                        || (cdb.valid && cdb.tag == disp.src2_tag);
                // whatever sits in the other slot is older
                older                <= ~disp_slot;
            end
            alu_res <= '{valid: issue_go, tag: ent_dest[issue_slot], data: result};
        end
    end

    always_ff @(posedge clk) begin
        for (int k = 0; k < 2; k++) begin
            if (!s1_rdy[k] && cdb.valid && cdb.tag == s1_tag[k]) begin
                s1_data[k] <= cdb.data;
            end
            if (!s2_rdy[k] && cdb.valid && cdb.tag == s2_tag[k]) begin
                s2_data[k] <= cdb.data;
            end
        end
        if (disp_hit) begin
            ent_op[disp_slot]   <= disp.op;
            ent_dest[disp_slot] <= disp.dest;
            s1_tag[disp_slot]   <= disp.src1_tag;
            s2_tag[disp_slot]   <= disp.src2_tag;
            s1_data[disp_slot]  <= (disp.src1_tag == '0) ? disp.src1_data : cdb.data;
            s2_data[disp_slot]  <= (disp.src2_tag == '0) ? disp.src2_data : cdb.data;
        end
    end

endmodule

// File: source/cdb_arbiter.sv
`timescale 1ns/1ns

module cdb_arbiter (
    input  logic          clk,
    input  logic          arst_n,
    input  logic          clr,
    input  lsq_pkg::cdb_t alu_res,
    input  lsq_pkg::cdb_t lsb_res,
    output lsq_pkg::cdb_t cdb,
    output logic          alu_busy,
    output logic          lsb_busy
);
    import lsq_pkg::*;

    cdb_t alu_hold;
    cdb_t lsb_hold;
    // alu wins the next contested cycle
    logic prio_alu;
    logic grant_alu;
    logic grant_lsb;

    assign alu_busy = alu_hold.valid;
    assign lsb_busy = lsb_hold.valid;

    assign grant_alu = alu_hold.valid && (!lsb_hold.valid || prio_alu);
    assign grant_lsb = lsb_hold.valid && !grant_alu;

    // an empty lsb hold carries valid low, so it doubles as the idle value
    assign cdb = grant_alu ? alu_hold : lsb_hold;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            alu_hold <= '0;
            lsb_hold <= '0;
            prio_alu <= 1'b1;
        end else if (clr) begin
            alu_hold.valid <= 1'b0;
            lsb_hold.valid <= 1'b0;
        end else begin
            // sources only send into an empty hold
            if (alu_res.valid) begin
                alu_hold <= alu_res;
            end else if (grant_alu) begin
                alu_hold.valid <= 1'b0;
            end
            if (lsb_res.valid) begin
                lsb_hold <= lsb_res;
            end else if (grant_lsb) begin
                lsb_hold.valid <= 1'b0;
            end
            if (alu_hold.valid && lsb_hold.valid) begin
                prio_alu <= ~prio_alu;
            end
        end
    end

endmodule

// File: source/data_memory.sv
`timescale 1ns/1ns
`include "lsq_defs.svh"

module data_memory (
    input  logic               clk,
    input  logic               arst_n,
    input  lsq_pkg::mem_req_t  mem_req,
    output lsq_pkg::mem_resp_t mem_resp
);
    import lsq_pkg::*;

    // request fields carried down the latency pipe
    typedef struct packed {
        logic                   valid;
        logic                   is_store;
        size_e                  size;
        logic                   is_unsigned;
        logic [`LSQ_TAG_W-1:0]  tag;
        logic [1:0]             offset;
        logic [`LSQ_DATA_W-1:0] word;
    } stage_t;

    logic [`LSQ_DATA_W-1:0] mem [`LSQ_MEM_WORDS] = '{default: '0};

    stage_t                              pipe [`LSQ_MEM_LAT];
    stage_t                              last;
    logic [$clog2(`LSQ_MEM_WORDS)-1:0]   widx;
    logic [3:0]                          lane_en;
    logic [`LSQ_DATA_W-1:0]              lane_data;
    logic [`LSQ_DATA_W-1:0]              shifted;

    assign widx = mem_req.addr[$clog2(`LSQ_MEM_WORDS)+1:2];

    // replicate the store data across lanes, enable only the addressed ones
    always_comb begin
        case (mem_req.size)
            BYTE: begin
                lane_en   = 4'b0001 << mem_req.addr[1:0];
                lane_data = {4{mem_req.wdata[7:0]}};
            end
            HALF: begin
                lane_en   = 4'b0011 << {mem_req.addr[1], 1'b0};
                lane_data = {2{mem_req.wdata[15:0]}};
            end
            default: begin
                lane_en   = 4'b1111;
                lane_data = mem_req.wdata;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (mem_req.valid && mem_req.is_store) begin
            for (int b = 0; b < 4; b++) begin
                if (lane_en[b]) begin
                    mem[widx][8*b +: 8] <= lane_data[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `LSQ_MEM_LAT; i++) begin
                pipe[i] <= '0;
            end
        end else begin
            pipe[0] <= '{
                valid:       mem_req.valid,
                is_store:    mem_req.is_store,
                size:        mem_req.size,
                is_unsigned: mem_req.is_unsigned,
                tag:         mem_req.tag,
                offset:      mem_req.addr[1:0],
                word:        mem[widx]
            };
            for (int i = 1; i < `LSQ_MEM_LAT; i++) begin
                pipe[i] <= pipe[i-1];
            end
        end
    end

    assign last    = pipe[`LSQ_MEM_LAT-1];
    assign shifted = last.word >> {last.offset, 3'b000};

    always_comb begin
        mem_resp.valid    = last.valid;
        mem_resp.is_store = last.is_store;
        mem_resp.tag      = last.tag;
        case (last.size)
            BYTE: mem_resp.data = last.is_unsigned ? `LSQ_DATA_W'(shifted[7:0])
                                                   : `LSQ_DATA_W'($signed(shifted[7:0]));
            HALF: mem_resp.data = last.is_unsigned ? `LSQ_DATA_W'(shifted[15:0])
                                                   : `LSQ_DATA_W'($signed(shifted[15:0]));
            default: mem_resp.data = shifted;
        endcase
    end

endmodule

// File: source/load_store_buffer.sv
`timescale 1ns/1ns
`include "lsq_defs.svh"

module load_store_buffer (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  clr,
    input  lsq_pkg::dispatch_t    disp,
    input  logic                  commit_valid,
    input  logic [`LSQ_TAG_W-1:0] commit_tag,
    input  lsq_pkg::cdb_t         cdb,
    input  logic                  lsb_busy,
    input  lsq_pkg::mem_resp_t    mem_resp,
    output lsq_pkg::mem_req_t     mem_req,
    output lsq_pkg::cdb_t         lsb_res,
    output logic                  full
);
    import lsq_pkg::*;

    // control bits, one per tag
    logic [`LSQ_ENTRIES-1:0] ent_valid;
    logic [`LSQ_ENTRIES-1:0] ent_store;
    logic [`LSQ_ENTRIES-1:0] s1_rdy;
    logic [`LSQ_ENTRIES-1:0] s2_rdy;
    logic [`LSQ_ENTRIES-1:0] committed;
    logic [`LSQ_ENTRIES-1:0] issued;
    logic                    pending;

    // entry payload
    op_e                    ent_op  [`LSQ_ENTRIES];
    logic [`LSQ_DATA_W-1:0] ent_imm [`LSQ_ENTRIES];
    logic [`LSQ_TAG_W-1:0]  s1_tag  [`LSQ_ENTRIES];
    logic [`LSQ_TAG_W-1:0]  s2_tag  [`LSQ_ENTRIES];
    logic [`LSQ_DATA_W-1:0] s1_data [`LSQ_ENTRIES];
    logic [`LSQ_DATA_W-1:0] s2_data [`LSQ_ENTRIES];

    logic                    disp_hit;
    logic                    disp_store;
    logic                    disp_s1_rdy;
    logic                    disp_s2_rdy;
    logic                    resp_hit;
    logic [`LSQ_ENTRIES-1:0] ld_cand;
    logic [`LSQ_ENTRIES-1:0] st_cand;
    logic                    issue_go;
    logic [`LSQ_TAG_W-1:0]   issue_tag;

    function automatic size_e op_size(input op_e op);
        case (op)
            LB, LBU, SB: return BYTE;
            LH, LHU, SH: return HALF;
            default:     return WORD;
        endcase
    endfunction

    assign disp_hit   = disp.valid && (disp.op inside {LB, LBU, LH, LHU, LW, SB, SH, SW});
    assign disp_store = disp.op inside {SB, SH, SW};

    // a broadcast in the dispatch cycle wakes the new operand as well
    assign disp_s1_rdy = (disp.src1_tag == '0) || (cdb.valid && cdb.tag == disp.src1_tag);
    assign disp_s2_rdy = (disp.src2_tag == '0) || (cdb.valid && cdb.tag == disp.src2_tag);

    // responses to entries flushed by clr are dropped here
    assign resp_hit = mem_resp.valid && ent_valid[mem_resp.tag] && issued[mem_resp.tag];

    assign lsb_res.valid = resp_hit && !mem_resp.is_store;
    assign lsb_res.tag   = mem_resp.tag;
    assign lsb_res.data  = mem_resp.data;

    // tag 0 is never allocated
    assign full = &ent_valid[`LSQ_ENTRIES-1:1];

    always_comb begin
        for (int i = 0; i < `LSQ_ENTRIES; i++) begin
            st_cand[i] = ent_valid[i] && ent_store[i] && committed[i]
                         && s1_rdy[i] && s2_rdy[i] && !issued[i];
            ld_cand[i] = ent_valid[i] && !ent_store[i] && s1_rdy[i] && !issued[i];
        end
    end

    // downward scans, so the lowest tag wins and committed stores go first
    always_comb begin
        issue_go  = 1'b0;
        issue_tag = '0;
        for (int i = `LSQ_ENTRIES - 1; i > 0; i--) begin
            if (ld_cand[i] && !lsb_busy) begin
                issue_go  = 1'b1;
                issue_tag = `LSQ_TAG_W'(i);
            end
        end
        for (int i = `LSQ_ENTRIES - 1; i > 0; i--) begin
            if (st_cand[i]) begin
                issue_go  = 1'b1;
                issue_tag = `LSQ_TAG_W'(i);
            end
        end
        if (pending) begin
            issue_go = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ent_valid <= '0;
            ent_store <= '0;
            s1_rdy    <= '0;
            s2_rdy    <= '0;
            committed <= '0;
            issued    <= '0;
            pending   <= 1'b0;
            mem_req   <= '0;
        end else begin
            // pending survives clr until the in-flight access returns
            if (issue_go && !clr) begin
                pending <= 1'b1;
            end else if (mem_resp.valid) begin
                pending <= 1'b0;
            end

            if (clr) begin
                ent_valid     <= '0;
                committed     <= '0;
                issued        <= '0;
                mem_req.valid <= 1'b0;
            end else begin
                for (int i = 0; i < `LSQ_ENTRIES; i++) begin
                    if (cdb.valid && cdb.tag == s1_tag[i]) begin
                        s1_rdy[i] <= 1'b1;
                    end
                    if (cdb.valid && cdb.tag == s2_tag[i]) begin
                        s2_rdy[i] <= 1'b1;
                    end
                end
                if (commit_valid) begin
                    committed[commit_tag] <= 1'b1;
                end
                if (issue_go) begin
                    issued[issue_tag] <= 1'b1;
                end
                if (resp_hit) begin
                    ent_valid[mem_resp.tag] <= 1'b0;
                end
                if (disp_hit) begin
                    ent_valid[disp.dest] <= 1'b1;
                    ent_store[disp.dest] <= disp_store;
                    s1_rdy[disp.dest]    <= disp_s1_rdy;
                    s2_rdy[disp.dest]    <= disp_s2_rdy;
                    committed[disp.dest] <= 1'b0;
                    issued[disp.dest]    <= 1'b0;
                end
                mem_req <= '{
                    valid:       issue_go,
                    is_store:    ent_store[issue_tag],
                    size:        op_size(ent_op[issue_tag]),
                    is_unsigned: ent_op[issue_tag] inside {LBU, LHU},
                    tag:         issue_tag,
                    addr:        s1_data[issue_tag] + ent_imm[issue_tag],
                    wdata:       s2_data[issue_tag]
                };
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `LSQ_ENTRIES; i++) begin
            if (!s1_rdy[i] && cdb.valid && cdb.tag == s1_tag[i]) begin
                s1_data[i] <= cdb.data;
            end
            if (!s2_rdy[i] && cdb.valid && cdb.tag == s2_tag[i]) begin
                s2_data[i] <= cdb.data;
            end
        end
        if (disp_hit) begin
            ent_op[disp.dest]  <= disp.op;
            ent_imm[disp.dest] <= disp.imm;
            s1_tag[disp.dest]  <= disp.src1_tag;
            s2_tag[disp.dest]  <= disp.src2_tag;
            s1_data[disp.dest] <= (disp.src1_tag == '0) ? disp.src1_data : cdb.data;
            s2_data[disp.dest] <= (disp.src2_tag == '0) ? disp.src2_data : cdb.data;
        end
    end

endmodule

// File: source/lsq_pkg.sv
`include "lsq_defs.svh"

package lsq_pkg;

    // alu class first, then loads, then stores
    typedef enum logic [3:0] {
        NOP, ADD, SUB, AND, OR, XOR,
        LB, LBU, LH, LHU, LW,
        SB, SH, SW
    } op_e;

    typedef enum logic [1:0] {
        BYTE,
        HALF,
        WORD
    } size_e;

    typedef struct packed {
        logic                   valid;
        op_e                    op;
        logic [`LSQ_TAG_W-1:0]  dest;
        logic [`LSQ_DATA_W-1:0] imm;
        logic [`LSQ_TAG_W-1:0]  src1_tag;
        logic [`LSQ_DATA_W-1:0] src1_data;
        logic [`LSQ_TAG_W-1:0]  src2_tag;
        logic [`LSQ_DATA_W-1:0] src2_data;
    } dispatch_t;

    // one result broadcast
    typedef struct packed {
        logic                   valid;
        logic [`LSQ_TAG_W-1:0]  tag;
        logic [`LSQ_DATA_W-1:0] data;
    } cdb_t;

    typedef struct packed {
        logic                   valid;
        logic                   is_store;
        size_e                  size;
        logic                   is_unsigned;
        logic [`LSQ_TAG_W-1:0]  tag;
        logic [`LSQ_DATA_W-1:0] addr;
        logic [`LSQ_DATA_W-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic                   valid;
        logic                   is_store;
        logic [`LSQ_TAG_W-1:0]  tag;
        logic [`LSQ_DATA_W-1:0] data;
    } mem_resp_t;

endpackage

// File: source/lsq_top.sv
`timescale 1ns/1ns
`include "lsq_defs.svh"

module lsq_top (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  clr,
    input  lsq_pkg::dispatch_t    disp,
    input  logic                  commit_valid,
    input  logic [`LSQ_TAG_W-1:0] commit_tag,
    output lsq_pkg::cdb_t         cdb,
    output logic                  full,
    output logic                  alu_full
);
    import lsq_pkg::*;

    // results heading for the bus
    cdb_t      alu_res;
    cdb_t      lsb_res;
    logic      alu_busy;
    logic      lsb_busy;

    // memory side
    mem_req_t  mem_req;
    mem_resp_t mem_resp;

    load_store_buffer i_lsb (
        .clk          (clk),
        .arst_n       (arst_n),
        .clr          (clr),
        .disp         (disp),
        .commit_valid (commit_valid),
        .commit_tag   (commit_tag),
        .cdb          (cdb),
        .lsb_busy     (lsb_busy),
        .mem_resp     (mem_resp),
        .mem_req      (mem_req),
        .lsb_res      (lsb_res),
        .full         (full)
    );

    alu_unit i_alu (
        .clk      (clk),
        .arst_n   (arst_n),
        .clr      (clr),
        .disp     (disp),
        .cdb      (cdb),
        .alu_busy (alu_busy),
        .alu_res  (alu_res),
        .alu_full (alu_full)
    );

    cdb_arbiter i_arb (
        .clk      (clk),
        .arst_n   (arst_n),
        .clr      (clr),
        .alu_res  (alu_res),
        .lsb_res  (lsb_res),
        .cdb      (cdb),
        .alu_busy (alu_busy),
        .lsb_busy (lsb_busy)
    );

    data_memory i_mem (
        .clk      (clk),
        .arst_n   (arst_n),
        .mem_req  (mem_req),
        .mem_resp (mem_resp)
    );

endmodule
